//--- common/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// histogram geometry
`define PIXEL_NUM 4     // pixels served by one memory
`define BIN_NUM   16    // time bins per pixel
`define BIN_W     4     // bin index width
`define PIX_W     2     // pixel index width

// memory word is pixel * BIN_NUM + bin
`define ADDR_W    6
`define CNT_W     16    // count word, saturating

// events per acquisition
`define LEN_W     24

// APB register map, byte offsets
`define REG_CTRL     12'h000  // bit 0 starts a run
`define REG_STATUS   12'h004  // bit 0 busy, bit 1 done
`define REG_LEN      12'h008  // events per run

// bins are read as words from here on
`define REG_BIN_BASE 12'h100

`endif

//--- common/histPkg.sv
`default_nettype none

`include "hist_defs.svh"

package histPkg;

    typedef struct packed {
        logic              valid;
        logic [`PIX_W-1:0] pixel;
        logic [`BIN_W-1:0] bin;    // time bin code from the front end
    } histEvent_t;

    typedef struct packed {
        logic               en;
        logic [`ADDR_W-1:0] addr;
        logic [`CNT_W-1:0]  data;
    } memWr_t;

    typedef struct packed {
        logic               en;
        logic [`ADDR_W-1:0] addr;
    } memRd_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,   // zero every word
        ACCUM,   // take events
        DRAIN,   // let the last write land
        DONE
    } ctrlState_t;

endpackage

`default_nettype wire

//--- common/apbPkg.sv
`default_nettype none

package apbPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;    // byte address
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

//--- histogram/histRam.sv
`default_nettype none

`include "hist_defs.svh"

module histRam
    import histPkg::*;
(
    input  wire logic             clk,
    input  wire memWr_t           memWr,
    input  wire memRd_t           memRd,
    output logic [`CNT_W-1:0]     rdData
);

    localparam int unsigned depth = `PIXEL_NUM * `BIN_NUM;

    logic [`CNT_W-1:0] mem [0:depth-1];

    // write port
    always_ff @(posedge clk) begin
        if (memWr.en) begin
            mem[memWr.addr] <= memWr.data;
        end
    end

    // registered read, old data on a same-word write
    always_ff @(posedge clk) begin
        if (memRd.en) begin
            rdData <= mem[memRd.addr];
        end
    end

endmodule

`default_nettype wire

//--- histogram/histCtrl.sv
`default_nettype none

`include "hist_defs.svh"

module histCtrl
    import histPkg::*;
(
    input  wire logic              clk,
    input  wire logic              res,
    input  wire logic              start,
    input  wire logic [`LEN_W-1:0] evLen,
    input  wire histEvent_t        evIn,
    output logic                   evReady,
    input  wire logic [`CNT_W-1:0] memRdData,
    output memRd_t                 memRd,
    output memWr_t                 memWr,
    output logic                   busy,
    output logic                   done
);

    localparam logic [`ADDR_W-1:0] lastAddr = `ADDR_W'(`PIXEL_NUM * `BIN_NUM - 1);

    ctrlState_t         state;
    ctrlState_t         nextState;
    logic [`ADDR_W-1:0] clrAddr;     // clear write pointer
    logic [`LEN_W-1:0]  remain;      // events still to take
    logic               drainCnt;
    logic               accept;
    logic               s1Valid;     // read in flight, write due now
    logic [`ADDR_W-1:0] s1Addr;
    memWr_t             wrPrev;      // write of the previous cycle
    logic               forward;
    logic [`CNT_W-1:0]  base;

    assign evReady = (state == ACCUM);
    assign busy    = state inside {CLEAR, ACCUM, DRAIN};
    assign done    = (state == DONE);
    assign accept  = evIn.valid && evReady;

    // read issued in the accept cycle
    assign memRd.en   = accept;
    assign memRd.addr = {evIn.pixel, evIn.bin};

    // memory returns old data when the previous event wrote the same word
    assign forward = wrPrev.en && (wrPrev.addr == s1Addr);
    assign base    = forward ? wrPrev.data : memRdData;

    always_comb begin
        memWr = '0;
        if (state == CLEAR) begin
            memWr.en   = 1'b1;
            memWr.addr = clrAddr;   // data stays zero
        end else if (s1Valid) begin
            memWr.en   = 1'b1;
            memWr.addr = s1Addr;
            memWr.data = (base == '1) ? base : base + 1'b1;  // saturate
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                if (clrAddr == lastAddr) begin
                    nextState = (remain == '0) ? DRAIN : ACCUM;
                end
            end
            ACCUM: begin
                if (accept && (remain == `LEN_W'(1))) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (drainCnt) begin
                    nextState = DONE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= IDLE;
            clrAddr  <= '0;
            remain   <= '0;
            drainCnt <= 1'b0;
            s1Valid  <= 1'b0;
            wrPrev   <= '0;
        end else begin
            state   <= nextState;
            s1Valid <= accept;
            wrPrev  <= memWr;
            if (state == CLEAR) begin
                clrAddr <= clrAddr + 1'b1;
            end else begin
                clrAddr <= '0;
            end
            if ((state == IDLE || state == DONE) && start) begin
                remain <= evLen;   // length fixed for the whole run
            end else if (accept) begin
                remain <= remain - 1'b1;
            end
            drainCnt <= (state == DRAIN) ? !drainCnt : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Addr <= memRd.addr;
        end
    end

    // memory is left alone once the run is over or before the first start
    noWriteIdle: assert property (@(posedge clk) disable iff (!res)
        (state inside {IDLE, DONE}) |-> !memWr.en);

    readyInAccum: assert property (@(posedge clk) disable iff (!res)
        (state != ACCUM) |-> !evReady);

endmodule

`default_nettype wire

//--- hdl/apbRegs.sv
`default_nettype none

`include "hist_defs.svh"

module apbRegs
    import apbPkg::*;
    import histPkg::*;
(
    input  wire logic              clk,
    input  wire logic              res,
    input  wire apbReq_t           apbIn,
    output apbRsp_t                apbOut,
    input  wire logic              busy,
    input  wire logic              done,
    input  wire logic [`CNT_W-1:0] memRdData,
    output logic                   start,
    output logic [`LEN_W-1:0]      evLen,
    output memRd_t                 memRd
);

    logic              setup;
    logic              access;
    logic [11:0]       binOff;
    logic              isBin;
    logic              binRd;
    logic              rdIssued;    // memory read went out in setup
    logic              waitDone;    // wait cycle passed, data held
    logic [`CNT_W-1:0] rdBuf;
    logic [31:0]       regData;

    assign setup  = apbIn.psel && !apbIn.penable;
    assign access = apbIn.psel && apbIn.penable;
    assign binOff = apbIn.paddr - `REG_BIN_BASE;
    assign isBin  = (apbIn.paddr >= `REG_BIN_BASE) && (binOff[11:`ADDR_W+2] == '0);
    assign binRd  = isBin && !apbIn.pwrite;

    // read port is ours only while the controller is idle
    assign memRd.en   = setup && binRd && !busy;
    assign memRd.addr = binOff[`ADDR_W+1:2];

    always_comb begin
        case (apbIn.paddr)
            `REG_STATUS: regData = {30'h0, done, busy};
            `REG_LEN:    regData = {{(32-`LEN_W){1'b0}}, evLen};
            default:     regData = 32'h0;   // CTRL reads back zero
        endcase
    end

    always_comb begin
        apbOut = '0;
        if (access) begin
            if (binRd) begin
                apbOut.pready  = !rdIssued || waitDone;
                apbOut.pslverr = !rdIssued;       // refused while busy
                apbOut.prdata  = waitDone ? {{(32-`CNT_W){1'b0}}, rdBuf} : 32'h0;
            end else if (isBin) begin
                apbOut.pready  = 1'b1;
                apbOut.pslverr = 1'b1;            // bins are read only
            end else begin
                apbOut.pready = 1'b1;
                apbOut.prdata = apbIn.pwrite ? 32'h0 : regData;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            start    <= 1'b0;
            evLen    <= '0;
            rdIssued <= 1'b0;
            waitDone <= 1'b0;
        end else begin
            start <= access && apbIn.pwrite && (apbIn.paddr == `REG_CTRL) && apbIn.pwdata[0];
            if (access && apbIn.pwrite && (apbIn.paddr == `REG_LEN)) begin
                evLen <= apbIn.pwdata[`LEN_W-1:0];
            end
            if (setup) begin
                rdIssued <= memRd.en;
                waitDone <= 1'b0;
            end else if (access && rdIssued) begin
                rdIssued <= !waitDone;   // drops when the transfer completes
                waitDone <= !waitDone;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && rdIssued && !waitDone) begin
            rdBuf <= memRdData;
        end
    end

    readyInAccess: assert property (@(posedge clk) disable iff (!res)
        apbOut.pready |-> (apbIn.psel && apbIn.penable));

endmodule

`default_nettype wire

//--- hdl/histTop.sv
`default_nettype none

`include "hist_defs.svh"

module histTop
    import apbPkg::*;
    import histPkg::*;
(
    input  wire logic       clk,
    input  wire logic       res,
    input  wire apbReq_t    apbIn,
    output apbRsp_t         apbOut,
    input  wire histEvent_t evIn,
    output logic            evReady
);

    logic              start;
    logic              busy;
    logic              done;
    logic [`LEN_W-1:0] evLen;
    logic [`CNT_W-1:0] memRdData;
    memRd_t            ctrlRd;
    memRd_t            apbRd;
    memRd_t            memRd;
    memWr_t            memWr;

    // controller owns the read port for the whole run
    assign memRd = busy ? ctrlRd : apbRd;

    histCtrl u_histCtrl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .evLen     (evLen),
        .evIn      (evIn),
        .evReady   (evReady),
        .memRdData (memRdData),
        .memRd     (ctrlRd),
        .memWr     (memWr),
        .busy      (busy),
        .done      (done)
    );

    histRam u_histRam (
        .clk    (clk),
        .memWr  (memWr),
        .memRd  (memRd),
        .rdData (memRdData)
    );

    apbRegs u_apbRegs (
        .clk       (clk),
        .res       (res),
        .apbIn     (apbIn),
        .apbOut    (apbOut),
        .busy      (busy),
        .done      (done),
        .memRdData (memRdData),
        .start     (start),
        .evLen     (evLen),
        .memRd     (apbRd)
    );

endmodule

`default_nettype wire

//--- testbench/histTb.sv
`default_nettype none

`include "hist_defs.svh"

module histTb
    import apbPkg::*;
    import histPkg::*;
();

    logic        clk;
    logic        res;
    apbReq_t     apbIn;
    apbRsp_t     apbOut;
    histEvent_t  evIn;
    logic        evReady;

    logic [`CNT_W-1:0] model [0:`PIXEL_NUM*`BIN_NUM-1];  // expected count per word
    logic [`LEN_W-1:0] lenReg;      // length as the host last wrote it
    logic              runActive;
    int                runLen;
    int                accCnt;      // handshakes in the current run
    int                evAddr;
    logic              expValid;    // compare read data on this transfer
    logic [31:0]       expData;
    logic              expErr;
    logic [31:0]       rdData;

    histTop u_histTop (
        .clk     (clk),
        .res     (res),
        .apbIn   (apbIn),
        .apbOut  (apbOut),
        .evIn    (evIn),
        .evReady (evReady)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    // bus and event monitor, all checks live here
    always @(posedge clk) begin
        if (!res) begin
            runActive = 1'b0;
            runLen    = 0;
            accCnt    = 0;
            lenReg    = '0;
            foreach (model[i]) model[i] = '0;
            assert (!evReady && !apbOut.pready) else
                stopRun($sformatf("[FAIL] evReady/pready in reset: got %h/%h, expected 0/0",
                                  evReady, apbOut.pready));
        end else begin
            assert (!evReady || runActive) else
                stopRun("evReady went high with no acquisition started");
            if (evIn.valid && evReady) begin
                assert (accCnt < runLen) else
                    stopRun($sformatf("[FAIL] accepted events: got %h, limit %h",
                                      accCnt + 1, runLen));
                evAddr = int'(evIn.pixel) * `BIN_NUM + int'(evIn.bin);
                if (model[evAddr] != '1) begin
                    model[evAddr] = model[evAddr] + 1'b1;  // saturating count
                end
                accCnt = accCnt + 1;
            end
            if (apbIn.psel && apbIn.penable && apbOut.pready) begin
                assert (apbOut.pslverr == expErr) else
                    stopRun($sformatf("[FAIL] apbOut.pslverr at %h: got %h, expected %h",
                                      apbIn.paddr, apbOut.pslverr, expErr));
                if (!apbIn.pwrite && expValid) begin
                    assert (apbOut.prdata == expData) else
                        stopRun($sformatf("[FAIL] apbOut.prdata at %h: got %h, expected %h",
                                          apbIn.paddr, apbOut.prdata, expData));
                end
                if (apbIn.pwrite && !expErr) begin
                    if (apbIn.paddr == `REG_LEN) begin
                        lenReg = apbIn.pwdata[`LEN_W-1:0];
                    end
                    if (apbIn.paddr == `REG_CTRL && apbIn.pwdata[0] && !runActive) begin
                        runActive = 1'b1;       // fresh clear, model starts at zero
                        runLen    = int'(lenReg);
                        accCnt    = 0;
                        foreach (model[i]) model[i] = '0;
                    end
                end
                if (!apbIn.pwrite && apbIn.paddr == `REG_STATUS && apbOut.prdata[1]
                    && runActive) begin
                    assert (accCnt == runLen) else
                        stopRun($sformatf("[FAIL] accepted events at done: got %h, expected %h",
                                          accCnt, runLen));
                    runActive = 1'b0;
                end
            end
        end
    end

    task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           input logic check, input logic [31:0] want, input logic err);
        int t;
        @(negedge clk);
        expValid      = check;
        expData       = want;
        expErr        = err;
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = wr;
        apbIn.paddr   = addr;
        apbIn.pwdata  = wdata;
        @(negedge clk);
        apbIn.penable = 1'b1;     // access phase
        t = 0;
        @(posedge clk);
        while (!apbOut.pready) begin
            t++;
            if (t > 4) stopRun("APB transfer never completed");
            @(posedge clk);
        end
        rdData = apbOut.prdata;
        @(negedge clk);
        apbIn = '0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] wdata, input logic err);
        apbXfer(1'b1, addr, wdata, 1'b0, 32'h0, err);
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic [31:0] want, input logic err);
        apbXfer(1'b0, addr, 32'h0, 1'b1, want, err);
    endtask

    // hazard mode sends pairs on one bin back to back
    task automatic sendEvents(input int n, input logic hazard);
        logic [31:0] r;
        int          gap;
        int          t;
        for (int i = 0; i < n; i++) begin
            r = $urandom();
            if (!hazard) begin
                gap  = int'(r[9:8]);
                evIn = '0;
                repeat (gap) @(negedge clk);
            end
            if (!hazard || i[0] == 1'b0) begin
                evIn.pixel = r[1:0];
                evIn.bin   = r[5:2];
            end
            evIn.valid = 1'b1;
            t = 0;
            while (!evReady) begin
                @(negedge clk);
                t++;
                if (t > 200) stopRun("event was never accepted");
            end
            @(negedge clk);       // taken on the edge in between
        end
        evIn = '0;
    endtask

    task automatic waitDone();
        int t;
        t      = 0;
        rdData = '0;
        while (!rdData[1]) begin
            apbXfer(1'b0, `REG_STATUS, 32'h0, 1'b0, 32'h0, 1'b0);
            t++;
            if (t > 50) stopRun("acquisition never reported done");
        end
    endtask

    task automatic checkBins();
        for (int a = 0; a < `PIXEL_NUM * `BIN_NUM; a++) begin
            apbRead(`REG_BIN_BASE + 12'(a * 4), 32'(model[a]), 1'b0);
        end
    endtask

    initial begin
        void'($urandom(45016));
        res      = 1'b0;
        apbIn    = '0;
        evIn     = '0;
        expValid = 1'b0;
        expData  = '0;
        expErr   = 1'b0;
        rdData   = '0;
        repeat (10) @(negedge clk);
        res = 1'b1;

        apbRead(`REG_STATUS, 32'h0, 1'b0);
        apbRead(`REG_LEN, 32'h0, 1'b0);

        apbWrite(`REG_LEN, 32'd200, 1'b0);
        apbRead(`REG_LEN, 32'd200, 1'b0);
        apbWrite(`REG_CTRL, 32'h1, 1'b0);
        apbRead(`REG_STATUS, 32'h1, 1'b0);     // busy, done cleared
        apbRead(`REG_BIN_BASE, 32'h0, 1'b1);   // refused during the run
        sendEvents(200, 1'b0);
        evIn.valid = 1'b1;                     // one more offer past the run length
        waitDone();
        evIn = '0;
        checkBins();

        apbWrite(`REG_LEN, 32'd64, 1'b0);
        apbWrite(`REG_CTRL, 32'h1, 1'b0);
        apbWrite(`REG_BIN_BASE + 12'h010, 32'h0000_beef, 1'b1);
        apbWrite(`REG_LEN, 32'd5, 1'b0);
        apbWrite(`REG_CTRL, 32'h1, 1'b0);      // second start while busy
        sendEvents(64, 1'b1);
        evIn.valid = 1'b1;
        waitDone();
        evIn = '0;
        checkBins();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/histPkg.sv
common/apbPkg.sv
histogram/histRam.sv
histogram/histCtrl.sv
hdl/apbRegs.sv
hdl/histTop.sv
testbench/histTb.sv

//--- run.sh
#!/bin/sh
# compile and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module histTb -f list.f -o histSim
./obj_dir/histSim
